/* tb.f */
+incdir+.
bus_pkg.sv
int_pkg.sv
tstate_fsm.sv
mcycle_counter.sv
bus_port.sv
int_ctrl.sv
bus_unit_top.sv
tb_bus_unit.sv

/* tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

	// -------------------------------------------------------------------------
	// failure exit
	// -------------------------------------------------------------------------

	task automatic stop_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped on first error");
	endtask

	// failures that are not a value mismatch
	task automatic report(input string what);
		$display("%0t: %s", $time, what);
		stop_run();
	endtask

	// -------------------------------------------------------------------------
	// compares, one per kind of result
	// -------------------------------------------------------------------------

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %02h expected %02h", $time, name, got, exp);
			stop_run();
		end
	endtask

	// addresses and restart vectors
	task automatic check_word(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %04h expected %04h", $time, name, got, exp);
			stop_run();
		end
	endtask

	task automatic check_pin(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
			stop_run();
		end
	endtask

`endif

/* tb_bus_unit.sv */
module tb_bus_unit;

	import bus_pkg::*;

	localparam int ADDR_W = 16;
	localparam int LIMIT = 200; // clocks one wait may take
	localparam int N_ROWS = 12;
	localparam int W_DONE = 0;
	localparam int W_IDLE = 1;
	localparam int W_HLDA = 2;
	localparam int W_ALE = 3;
	localparam int W_VEC = 4;

	logic clk = 1'b0;
	logic rst;
	logic i_req, i_hold, i_sim, i_ie_wr, i_ie_val, i_sid;
	logic i_rst75, i_rst65, i_rst55, i_trap;
	logic i_ready = 1'b1;
	cycle_t i_cycle;
	logic [ADDR_W-1:0] i_addr;
	logic [BURST_W-1:0] i_len;
	data_t i_wdata, i_sim_data;
	data_t i_ad_in = '0;
	logic o_busy, o_done, o_rvalid, o_hlda, o_ad_oe, o_addr_oe, o_ale;
	logic o_rd_n, o_wr_n, o_inta_n, o_iom_n, o_s1, o_s0, o_pending, o_sod;
	data_t o_rdata, o_ad_out, o_addr_hi, o_rim;
	logic [15:0] o_vector;

	// stimulus table with one row per request
	cycle_t t_cyc [N_ROWS];
	logic [15:0] t_addr [N_ROWS];
	logic [1:0] t_len [N_ROWS];
	data_t t_wdata [N_ROWS];
	data_t t_rd0 [N_ROWS]; // first read byte
	logic [2:0] t_stat [N_ROWS]; // {io/m_, s1, s0}
	bit t_hold [N_ROWS];
	int n_rows = 0;

	// bus model state
	data_t mem [0:65535]; // written bytes
	logic [15:0] lat_addr = '0; // latched on ale
	logic [15:0] ale_q [$];
	data_t rd_q [$];
	logic [2:0] cur_stat = '0;
	bit cur_rd, cur_wr, cur_ina;
	int cur_ncyc = 0; // machine cycles of the running request
	int strobe_cnt = 0;
	int done_cnt = 0;
	int wait_left = 0;
	int seed = 32'hd5c9;
	logic [15:0] want_vec;

	`include "tb_checks.svh"

	bus_unit_top #(.ADDR_W(ADDR_W)) u_bus_unit_top (.*);

	always #50 clk = ~clk;

	function automatic data_t rule_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8]; // memory answers lo xor hi
	endfunction

	// address seen on the bus in cycle k of row r
	function automatic logic [15:0] bus_addr(input int r, input int k);
		logic [15:0] a;
		a = t_addr[r] + k;
		if (t_stat[r] == 3'b110 || t_stat[r] == 3'b101)
			a = {a[7:0], a[7:0]}; // port byte on both halves
		return a;
	endfunction

	task automatic add_row(input cycle_t c, input logic [15:0] a, input logic [1:0] n,
		input data_t wd, input data_t rd, input logic [2:0] st, input bit h);
		t_cyc[n_rows] = c;
		t_addr[n_rows] = a;
		t_len[n_rows] = n;
		t_wdata[n_rows] = wd;
		t_rd0[n_rows] = rd;
		t_stat[n_rows] = st;
		t_hold[n_rows] = h;
		n_rows++;
	endtask

	function automatic bit cond_met(input int what);
		case (what)
			W_DONE: return o_done;
			W_IDLE: return !o_busy;
			W_HLDA: return o_hlda;
			W_ALE: return o_ale;
			default: return o_vector == want_vec;
		endcase
	endfunction

	task automatic wait_until(input int what, input string name);
		int n;
		n = 0;
		@(negedge clk);
		while (!cond_met(what) && n < LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!cond_met(what))
			report({"timed out waiting for ", name});
	endtask

	// rising edge plus the input delay
	task automatic drive_slot();
		@(posedge clk);
		#5;
	endtask

	// one sim or ie write then settle to the negative edge
	task automatic ctrl_write(input logic sim, input data_t d, input logic ie);
		@(posedge clk);
		#5;
		i_sim = sim;
		i_sim_data = d;
		i_ie_wr = ~sim;
		i_ie_val = ie;
		@(posedge clk);
		#5;
		i_sim = 1'b0;
		i_ie_wr = 1'b0;
		@(negedge clk);
	endtask

	// -------------------------------------------------------------------------
	// bus model drives its inputs 5 units after the rising edge
	// -------------------------------------------------------------------------

	always @(posedge clk) begin
		#5;
		i_ad_in = rule_byte(lat_addr);
		if (wait_left > 0) begin
			i_ready = 1'b0; // still in a wait span
			wait_left = wait_left - 1;
		end else if (($random(seed) & 7) == 0) begin
			i_ready = 1'b0;
			wait_left = $random(seed) & 3; // up to 4 clocks low
		end else begin
			i_ready = 1'b1;
		end
	end

	// monitor samples mid cycle
	always @(negedge clk) begin
		if (!rst) begin
			if (o_ale) begin
				lat_addr = {o_addr_hi, o_ad_out};
				ale_q.push_back(lat_addr);
				check_pin("o_addr_oe", o_addr_oe, 1'b1);
				check_pin("o_ad_oe", o_ad_oe, 1'b1);
				check_pin("o_iom_n", o_iom_n, cur_stat[2]);
				check_pin("o_s1", o_s1, cur_stat[1]);
				check_pin("o_s0", o_s0, cur_stat[0]);
			end
			if (!o_rd_n || !o_wr_n || !o_inta_n) begin
				check_pin("o_rd_n", o_rd_n, !cur_rd); // only the cycle's strobe
				check_pin("o_wr_n", o_wr_n, !cur_wr);
				check_pin("o_inta_n", o_inta_n, !cur_ina);
				strobe_cnt++;
			end
			if (!o_wr_n) begin
				check_pin("o_ad_oe", o_ad_oe, 1'b1);
				mem[lat_addr] = o_ad_out; // record the write
			end
			if (o_rvalid)
				rd_q.push_back(o_rdata);
			if (o_done) begin
				done_cnt++;
				if (ale_q.size() != cur_ncyc)
					report("o_done came before the last machine cycle");
			end
			if (o_hlda) begin
				check_pin("o_addr_oe", o_addr_oe, 1'b0); // bus released
				check_pin("o_ad_oe", o_ad_oe, 1'b0);
				check_pin("o_ale", o_ale, 1'b0);
				check_pin("o_rd_n", o_rd_n, 1'b1);
				check_pin("o_wr_n", o_wr_n, 1'b1);
				check_pin("o_inta_n", o_inta_n, 1'b1);
			end
		end
	end

	// -------------------------------------------------------------------------
	// one request from the table
	// -------------------------------------------------------------------------

	task automatic run_row(input int r);
		int n_cyc;
		n_cyc = t_len[r] + 1;
		cur_ncyc = n_cyc;
		cur_stat = t_stat[r];
		cur_wr = !t_stat[r][1]; // s1 low means write
		cur_ina = (t_stat[r] == 3'b111);
		cur_rd = t_stat[r][1] && !cur_ina;
		strobe_cnt = 0;
		done_cnt = 0;
		ale_q.delete();
		rd_q.delete();
		@(posedge clk);
		#5;
		i_cycle = t_cyc[r];
		i_addr = t_addr[r];
		i_len = t_len[r];
		i_wdata = t_wdata[r];
		i_req = 1'b1;
		@(posedge clk);
		#5;
		i_req = 1'b0;
		check_pin("o_busy", o_busy, 1'b1);
		if (t_hold[r]) begin
			wait_until(W_ALE, "first ALE");
			@(posedge clk);
			#5;
			i_hold = 1'b1;
			wait_until(W_HLDA, "HLDA");
			if (ale_q.size() != 1)
				report("hold not taken at the first cycle boundary");
			check_pin("o_busy", o_busy, 1'b1);
			repeat (3) @(posedge clk);
			#5;
			i_hold = 1'b0;
		end
		wait_until(W_DONE, "burst done");
		wait_until(W_IDLE, "busy to fall");
		@(posedge clk);
		#5;
		if (done_cnt != 1)
			report("o_done was not a single pulse");
		if (ale_q.size() != n_cyc)
			report("wrong number of ALE strobes");
		if (rd_q.size() != (cur_wr ? 0 : n_cyc))
			report("wrong number of read bytes");
		if (strobe_cnt < 2 * n_cyc)
			report("strobe too short");
		for (int k = 0; k < n_cyc; k++) begin
			check_word("{o_addr_hi, o_ad_out}", ale_q[k], bus_addr(r, k));
			if (cur_wr) begin
				check_data("o_ad_out", mem[bus_addr(r, k)], t_wdata[r]);
			end else begin
				check_data("o_rdata", rd_q[k], rule_byte(bus_addr(r, k)));
				if (k == 0)
					check_data("o_rdata", rd_q[0], t_rd0[r]);
			end
		end
	endtask

	task automatic check_int(input logic [15:0] vec, input data_t rim, input string name);
		want_vec = vec;
		wait_until(W_VEC, name);
		check_data("o_rim", o_rim, rim);
		check_pin("o_pending", o_pending, vec != 16'h0000);
	endtask

	initial begin
		rst = 1'b1;
		i_req = 1'b0;
		i_cycle = CYC_OF;
		i_addr = '0;
		i_len = '0;
		i_wdata = '0;
		i_hold = 1'b0;
		i_sim = 1'b0;
		i_sim_data = '0;
		i_ie_wr = 1'b0;
		i_ie_val = 1'b0;
		i_rst75 = 1'b0;
		i_rst65 = 1'b0;
		i_rst55 = 1'b0;
		i_trap = 1'b0;
		i_sid = 1'b0;
		//      cycle    addr      len  wdata  rd0    stat    hold
		add_row(CYC_OF, 16'h1234, 2'd0, 8'h00, 8'h26, 3'b011, 1'b0);
		add_row(CYC_MR, 16'h20F0, 2'd3, 8'h00, 8'hD0, 3'b010, 1'b0);
		add_row(CYC_OF, 16'h80FE, 2'd2, 8'h00, 8'h7E, 3'b011, 1'b0); // carry to 8100
		add_row(CYC_MR, 16'h4501, 2'd1, 8'h00, 8'h44, 3'b010, 1'b0);
		add_row(CYC_MW, 16'h3000, 2'd3, 8'hA5, 8'h00, 3'b001, 1'b0);
		add_row(CYC_MW, 16'h3100, 2'd0, 8'h5A, 8'h00, 3'b001, 1'b0);
		add_row(CYC_IOR, 16'h0042, 2'd1, 8'h00, 8'h00, 3'b110, 1'b0);
		add_row(CYC_IOW, 16'h0080, 2'd0, 8'hC3, 8'h00, 3'b101, 1'b0);
		add_row(CYC_INA, 16'h00FF, 2'd0, 8'h00, 8'hFF, 3'b111, 1'b0);
		add_row(CYC_MR, 16'h5600, 2'd3, 8'h00, 8'h56, 3'b010, 1'b1);
		add_row(CYC_OF, 16'h7000, 2'd1, 8'h00, 8'h70, 3'b011, 1'b1);
		add_row(CYC_MW, 16'h3200, 2'd2, 8'h3C, 8'h00, 3'b001, 1'b1);
		repeat (16) @(posedge clk);
		#5;
		rst = 1'b0;
		@(negedge clk);
		check_pin("o_rd_n", o_rd_n, 1'b1);
		check_pin("o_wr_n", o_wr_n, 1'b1);
		check_pin("o_inta_n", o_inta_n, 1'b1);
		check_pin("o_ale", o_ale, 1'b0);
		check_pin("o_hlda", o_hlda, 1'b0);
		check_pin("o_busy", o_busy, 1'b0);
		check_pin("o_ad_oe", o_ad_oe, 1'b0);
		check_pin("o_addr_oe", o_addr_oe, 1'b0);
		check_data("o_rim", o_rim, 8'h07); // masks set
		for (int r = 0; r < n_rows; r++)
			run_row(r);

		// ---------------------------------------------------------------------
		// interrupts
		// ---------------------------------------------------------------------
		ctrl_write(1'b1, 8'hC8, 1'b0); // sod on and masks open
		check_pin("o_sod", o_sod, 1'b1);
		check_int(16'h0000, 8'h00, "masks open");
		ctrl_write(1'b0, 8'h00, 1'b1);
		check_int(16'h0000, 8'h08, "enable");
		drive_slot();
		i_rst55 = 1'b1;
		check_int(16'h002C, 8'h18, "rst5.5 vector");
		drive_slot();
		i_rst65 = 1'b1;
		check_int(16'h0034, 8'h38, "rst6.5 vector");
		drive_slot();
		i_rst75 = 1'b1;
		check_int(16'h003C, 8'h78, "rst7.5 vector");
		drive_slot();
		i_rst75 = 1'b0;
		repeat (4) @(posedge clk); // edge stays latched
		check_int(16'h003C, 8'h78, "rst7.5 latch");
		drive_slot();
		i_trap = 1'b1;
		check_int(16'h0024, 8'h78, "trap vector");
		drive_slot();
		i_trap = 1'b0; // level gone so the latch alone is not enough
		check_int(16'h003C, 8'h78, "trap level drop");
		drive_slot();
		i_sid = 1'b1;
		check_int(16'h003C, 8'hF8, "sid in rim");
		run_row(8); // inta serves 7.5
		check_int(16'h0000, 8'hB0, "enable and 7.5 cleared");
		ctrl_write(1'b0, 8'h00, 1'b1);
		check_int(16'h0034, 8'hB8, "re-enable");
		ctrl_write(1'b1, 8'h0A, 1'b0); // mask 6.5
		check_int(16'h002C, 8'hBA, "rst6.5 masked");
		check_pin("o_sod", o_sod, 1'b1);
		ctrl_write(1'b1, 8'h40, 1'b0); // sde with sod low
		check_pin("o_sod", o_sod, 1'b0);
		check_int(16'h002C, 8'hBA, "masks kept");
		drive_slot();
		i_rst75 = 1'b1;
		check_int(16'h003C, 8'hFA, "second rst7.5 edge");
		drive_slot();
		i_rst75 = 1'b0;
		ctrl_write(1'b1, 8'h1A, 1'b0); // r75 clears the latch
		check_int(16'h002C, 8'hBA, "rst7.5 reset by sim");
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* bus_unit_top.sv */
module bus_unit_top #(
	parameter int ADDR_W = 16
) (
	input logic clk,
	input logic rst,
	// host request
	input logic i_req,
	input bus_pkg::cycle_t i_cycle,
	input logic [ADDR_W-1:0] i_addr,
	input logic [bus_pkg::BURST_W-1:0] i_len,
	input bus_pkg::data_t i_wdata,
	output logic o_busy,
	output logic o_done,
	output bus_pkg::data_t o_rdata,
	output logic o_rvalid,
	// bus side
	input logic i_ready,
	input logic i_hold,
	output logic o_hlda,
	input bus_pkg::data_t i_ad_in,
	output bus_pkg::data_t o_ad_out,
	output logic o_ad_oe,
	output bus_pkg::data_t o_addr_hi,
	output logic o_addr_oe,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_inta_n,
	output logic o_iom_n,
	output logic o_s1,
	output logic o_s0,
	// interrupts and serial
	input logic i_sim,
	input bus_pkg::data_t i_sim_data,
	input logic i_ie_wr,
	input logic i_ie_val,
	input logic i_rst75,
	input logic i_rst65,
	input logic i_rst55,
	input logic i_trap,
	input logic i_sid,
	output logic o_pending,
	output logic [15:0] o_vector,
	output bus_pkg::data_t o_rim,
	output logic o_sod
);

	import bus_pkg::*;

	tstate_t state_w;
	logic step_w; // end of each machine cycle
	logic last_w;
	logic ack_w; // end of an inta cycle
	logic [ADDR_W-1:0] addr_w;

	tstate_fsm u_tstate_fsm (
		.clk (clk), .rst (rst),
		.i_req (i_req), .i_cycle (i_cycle), .i_ready (i_ready),
		.i_hold (i_hold), .i_last (last_w),
		.o_state (state_w), .o_step (step_w), .o_done (o_done),
		.o_ack (ack_w), .o_busy (o_busy), .o_hlda (o_hlda)
	);

	mcycle_counter #(.ADDR_W(ADDR_W)) u_mcycle_counter (
		.clk (clk), .rst (rst),
		.i_load (i_req & ~o_busy), // same condition the fsm accepts on
		.i_len (i_len), .i_addr (i_addr), .i_step (step_w),
		.o_addr (addr_w), .o_last (last_w)
	);

	bus_port #(.ADDR_W(ADDR_W)) u_bus_port (
		.clk (clk), .rst (rst),
		.i_state (state_w), .i_cycle (i_cycle), .i_addr (addr_w),
		.i_wdata (i_wdata), .i_ad_in (i_ad_in),
		.o_addr_hi (o_addr_hi), .o_ad_out (o_ad_out), .o_ad_oe (o_ad_oe),
		.o_addr_oe (o_addr_oe), .o_ale (o_ale), .o_rd_n (o_rd_n),
		.o_wr_n (o_wr_n), .o_inta_n (o_inta_n), .o_iom_n (o_iom_n),
		.o_s1 (o_s1), .o_s0 (o_s0), .o_rdata (o_rdata), .o_rvalid (o_rvalid)
	);

	int_ctrl u_int_ctrl (
		.clk (clk), .rst (rst),
		.i_sim (i_sim), .i_sim_data (i_sim_data),
		.i_ie_wr (i_ie_wr), .i_ie_val (i_ie_val), .i_ack (ack_w),
		.i_rst75 (i_rst75), .i_rst65 (i_rst65), .i_rst55 (i_rst55),
		.i_trap (i_trap), .i_sid (i_sid),
		.o_pending (o_pending), .o_vector (o_vector), .o_rim (o_rim), .o_sod (o_sod)
	);

endmodule

/* int_ctrl.sv */
module int_ctrl (
	input logic clk,
	input logic rst,
	input logic i_sim,
	input bus_pkg::data_t i_sim_data,
	input logic i_ie_wr,
	input logic i_ie_val,
	input logic i_ack,
	input logic i_rst75,
	input logic i_rst65,
	input logic i_rst55,
	input logic i_trap,
	input logic i_sid,
	output logic o_pending,
	output logic [15:0] o_vector,
	output bus_pkg::data_t o_rim,
	output logic o_sod
);

	import int_pkg::*;

	// sync vector layout
	localparam int S_TRAP = 3;
	localparam int S_75 = 2;
	localparam int S_65 = 1;
	localparam int S_55 = 0;

	logic [3:0] sync1_q;
	logic [3:0] sync2_q; // synchronized request lines
	logic [1:0] prev_q; // {trap, 7.5} one clock back, for edges
	logic [2:0] mask_q; // set = masked
	logic ie_q;
	logic sod_q;
	logic r75_q; // rst7.5 edge latch
	logic trap_q; // trap edge latch
	logic edge_75;
	logic edge_trap;
	logic trap_req;
	logic sel_trap;
	logic sel_75;
	logic sel_65;
	logic sel_55;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			sync1_q <= '0;
			sync2_q <= '0;
			prev_q <= '0;
		end else begin
			sync1_q <= {i_trap, i_rst75, i_rst65, i_rst55};
			sync2_q <= sync1_q;
			prev_q <= {sync2_q[S_TRAP], sync2_q[S_75]};
		end
	end

	assign edge_trap = sync2_q[S_TRAP] & ~prev_q[1];
	assign edge_75 = sync2_q[S_75] & ~prev_q[0];

	// -------------------------------------------------------------------------
	// sim, enable and latches
	// -------------------------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			mask_q <= 3'b111; // all masked out of reset
			ie_q <= 1'b0;
			sod_q <= 1'b0;
			r75_q <= 1'b0;
			trap_q <= 1'b0;
		end else begin
			if (i_sim && i_sim_data[SIM_MSE])
				mask_q <= i_sim_data[MASK_75:MASK_55];
			if (i_sim && i_sim_data[SIM_SDE])
				sod_q <= i_sim_data[SIM_SOD];
			if (i_ie_wr)
				ie_q <= i_ie_val;
			if (i_ack)
				ie_q <= 1'b0; // acknowledge disables further requests
			if ((i_ack && sel_75) || (i_sim && i_sim_data[SIM_R75]))
				r75_q <= 1'b0;
			if (edge_75)
				r75_q <= 1'b1; // new edge wins over a clear
			if (i_ack && sel_trap)
				trap_q <= 1'b0;
			if (edge_trap)
				trap_q <= 1'b1;
		end
	end

	// trap wants the edge and a level still high
	assign trap_req = trap_q & sync2_q[S_TRAP];

	// fixed priority trap, 7.5, 6.5, 5.5
	assign sel_trap = trap_req;
	assign sel_75 = ~trap_req & ie_q & ~mask_q[MASK_75] & r75_q;
	assign sel_65 = ~trap_req & ~sel_75 & ie_q & ~mask_q[MASK_65] & sync2_q[S_65];
	assign sel_55 = ~trap_req & ~sel_75 & ~sel_65 & ie_q & ~mask_q[MASK_55] & sync2_q[S_55];

	assign o_pending = sel_trap | sel_75 | sel_65 | sel_55;

	always_comb begin
		if (sel_trap)
			o_vector = VEC_TRAP;
		else if (sel_75)
			o_vector = VEC_75;
		else if (sel_65)
			o_vector = VEC_65;
		else if (sel_55)
			o_vector = VEC_55;
		else
			o_vector = VEC_NONE;
	end

	// rim shows raw requests, independent of mask and enable
	assign o_rim = {i_sid, r75_q, sync2_q[S_65], sync2_q[S_55], ie_q, mask_q};
	assign o_sod = sod_q;

endmodule

/* bus_port.sv */
module bus_port #(
	parameter int ADDR_W = 16
) (
	input logic clk,
	input logic rst,
	input bus_pkg::tstate_t i_state,
	input bus_pkg::cycle_t i_cycle,
	input logic [ADDR_W-1:0] i_addr,
	input bus_pkg::data_t i_wdata,
	input bus_pkg::data_t i_ad_in,
	output bus_pkg::data_t o_addr_hi,
	output bus_pkg::data_t o_ad_out,
	output logic o_ad_oe,
	output logic o_addr_oe,
	output logic o_ale,
	output logic o_rd_n,
	output logic o_wr_n,
	output logic o_inta_n,
	output logic o_iom_n,
	output logic o_s1,
	output logic o_s0,
	output bus_pkg::data_t o_rdata,
	output logic o_rvalid
);

	import bus_pkg::*;

	logic [2:0] stat_sel; // {io/m_, s1, s0} of the cycle
	logic active; // T1 through T4
	logic strobe; // rd_/wr_/inta_ window
	logic is_rd;
	logic is_wr;
	logic is_io;
	logic is_ina;
	logic rd_take; // capture read byte this clock
	data_t addr_lo;

	always_comb begin
		case (i_cycle)
			CYC_OF: stat_sel = STAT_OF;
			CYC_MR: stat_sel = STAT_MR;
			CYC_MW: stat_sel = STAT_MW;
			CYC_IOR: stat_sel = STAT_IOR;
			CYC_IOW: stat_sel = STAT_IOW;
			CYC_INA: stat_sel = STAT_INA;
			default: stat_sel = STAT_IDLE;
		endcase
	end

	assign is_io = (i_cycle == CYC_IOR) || (i_cycle == CYC_IOW);
	assign is_ina = (i_cycle == CYC_INA);
	assign is_rd = (i_cycle == CYC_OF) || (i_cycle == CYC_MR) || (i_cycle == CYC_IOR);
	assign is_wr = (i_cycle == CYC_MW) || (i_cycle == CYC_IOW);

	assign active = (i_state inside {T_1, T_2, T_W, T_3, T_4});
	assign strobe = (i_state inside {T_2, T_W, T_3});

	// -------------------------------------------------------------------------
	// address, data and pins
	// -------------------------------------------------------------------------

	assign addr_lo = i_addr[DATA_W-1:0];
	assign o_addr_hi = is_io ? addr_lo : i_addr[ADDR_W-1 -: DATA_W]; // port on both halves
	assign o_addr_oe = active; // released in idle and hold

	// ad carries the low address in T1, then write data
	assign o_ad_oe = (i_state == T_1) | (strobe & is_wr);
	assign o_ad_out = (i_state == T_1) ? addr_lo : i_wdata;

	assign o_ale = (i_state == T_1);
	assign o_rd_n = ~(strobe & is_rd);
	assign o_wr_n = ~(strobe & is_wr);
	assign o_inta_n = ~(strobe & is_ina); // stands in for rd_

	// status idles at 000 outside a cycle
	assign o_iom_n = active & stat_sel[STAT_IOM];
	assign o_s1 = active & stat_sel[STAT_S1];
	assign o_s0 = active & stat_sel[STAT_S0];

	// -------------------------------------------------------------------------
	// read capture, closing edge of T3
	// -------------------------------------------------------------------------

	assign rd_take = (i_state == T_3) & (is_rd | is_ina);

	always_ff @(posedge clk) begin
		if (rd_take)
			o_rdata <= i_ad_in;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			o_rvalid <= 1'b0;
		else
			o_rvalid <= rd_take; // one pulse per read cycle
	end

endmodule

/* mcycle_counter.sv */
module mcycle_counter #(
	parameter int ADDR_W = 16
) (
	input logic clk,
	input logic rst,
	input logic i_load,
	input logic [bus_pkg::BURST_W-1:0] i_len,
	input logic [ADDR_W-1:0] i_addr,
	input logic i_step,
	output logic [ADDR_W-1:0] o_addr,
	output logic o_last
);

	import bus_pkg::*;

	logic [BURST_W-1:0] cnt_q; // cycles left after the current one
	logic [ADDR_W-1:0] addr_q; // address of the current cycle

	// -------------------------------------------------------------------------
	// count and address
	// -------------------------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cnt_q <= '0;
			addr_q <= '0;
		end else if (i_load) begin
			cnt_q <= i_len;
			addr_q <= i_addr;
		end else if (i_step) begin
			addr_q <= addr_q + 1'b1; // one byte per machine cycle
			if (cnt_q != '0)
				cnt_q <= cnt_q - 1'b1; // parks at zero after the burst
		end
	end

	assign o_addr = addr_q;
	assign o_last = (cnt_q == '0);

endmodule

/* tstate_fsm.sv */
module tstate_fsm (
	input logic clk,
	input logic rst,
	input logic i_req,
	input bus_pkg::cycle_t i_cycle,
	input logic i_ready,
	input logic i_hold,
	input logic i_last,
	output bus_pkg::tstate_t o_state,
	output logic o_step,
	output logic o_done,
	output logic o_ack,
	output logic o_busy,
	output logic o_hlda
);

	import bus_pkg::*;

	tstate_t state_q;
	tstate_t state_d;
	cycle_t cyc_q; // opcode of the running burst
	logic fin_q; // burst already done when hold was entered
	logic end_cyc; // last state of a machine cycle

	// T3 closes every cycle but opcode fetch, which runs on into T4
	assign end_cyc = (state_q == T_3 && cyc_q != CYC_OF) || state_q == T_4;

	// -------------------------------------------------------------------------
	// next state
	// -------------------------------------------------------------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			T_IDLE: begin
				if (i_req)
					state_d = T_1;
			end
			T_1: begin
				state_d = T_2;
			end
			T_2, T_W: begin
				if (i_ready) // ready sampled every clock of T2/TW
					state_d = T_3;
				else
					state_d = T_W;
			end
			T_3, T_4: begin
				if (!end_cyc) begin
					state_d = T_4; // fetch gets its extra state
				end else if (i_hold) begin
					state_d = T_H; // hold only at a cycle boundary
				end else if (i_last) begin
					state_d = T_IDLE;
				end else begin
					state_d = T_1; // next cycle of the burst
				end
			end
			T_H: begin
				if (!i_hold)
					state_d = fin_q ? T_IDLE : T_1;
			end
			default: begin
				state_d = T_IDLE;
			end
		endcase
	end

	// -------------------------------------------------------------------------
	// state register, rising edge
	// -------------------------------------------------------------------------

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= T_IDLE;
			cyc_q <= CYC_OF;
			fin_q <= 1'b0;
		end else begin
			state_q <= state_d;
			if (state_q == T_IDLE && i_req)
				cyc_q <= i_cycle; // held for the whole burst
			if (end_cyc)
				fin_q <= i_last; // remembered across T_H
		end
	end

	// outputs decoded from the state register
	assign o_state = state_q;
	assign o_step = end_cyc; // counter steps once per cycle
	assign o_done = end_cyc & i_last;
	assign o_ack = end_cyc & (cyc_q == CYC_INA);
	assign o_busy = (state_q != T_IDLE); // stays up through hold
	assign o_hlda = (state_q == T_H);

endmodule

/* int_pkg.sv */
package int_pkg;

	// sim byte layout, bit 5 unused
	localparam int SIM_SOD = 7; // serial out data
	localparam int SIM_SDE = 6; // sod write enable
	localparam int SIM_R75 = 4; // clears the rst7.5 latch
	localparam int SIM_MSE = 3; // mask set enable

	// mask bits, shared by sim and rim
	localparam int MASK_75 = 2;
	localparam int MASK_65 = 1;
	localparam int MASK_55 = 0;

	// -------------------------------------------------------------------------
	// restart vectors
	// -------------------------------------------------------------------------

	localparam logic [15:0] VEC_TRAP = 16'h0024; // rst 4.5
	localparam logic [15:0] VEC_75 = 16'h003C;
	localparam logic [15:0] VEC_65 = 16'h0034;
	localparam logic [15:0] VEC_55 = 16'h002C;
	localparam logic [15:0] VEC_NONE = 16'h0000; // nothing pending

endpackage

/* bus_pkg.sv */
package bus_pkg;

	// -------------------------------------------------------------------------
	// data path
	// -------------------------------------------------------------------------

	localparam int DATA_W = 8; // 8085 data bus
	typedef logic [DATA_W-1:0] data_t;

	// burst length field, value n gives n+1 machine cycles
	localparam int BURST_W = 2;

	// -------------------------------------------------------------------------
	// machine cycles and T-states
	// -------------------------------------------------------------------------

	typedef enum logic [2:0] {
		CYC_OF, // opcode fetch, gets a T4
		CYC_MR, // memory read
		CYC_MW, // memory write
		CYC_IOR, // device read
		CYC_IOW, // device write
		CYC_INA // interrupt acknowledge
	} cycle_t;

	typedef enum logic [2:0] {
		T_IDLE,
		T_1, // ale, address out
		T_2,
		T_W, // wait while ready low
		T_3,
		T_4, // opcode fetch only
		T_H // bus released
	} tstate_t;

	// -------------------------------------------------------------------------
	// status pins {io/m_, s1, s0}
	// -------------------------------------------------------------------------

	localparam int STAT_IOM = 2;
	localparam int STAT_S1 = 1;
	localparam int STAT_S0 = 0;

	localparam logic [2:0] STAT_OF = 3'b011;
	localparam logic [2:0] STAT_MR = 3'b010;
	localparam logic [2:0] STAT_MW = 3'b001;
	localparam logic [2:0] STAT_IOR = 3'b110;
	localparam logic [2:0] STAT_IOW = 3'b101;
	localparam logic [2:0] STAT_INA = 3'b111;
	localparam logic [2:0] STAT_IDLE = 3'b000; // between bursts and in hold

endpackage
